// ==== compile.f ====
+incdir+rtl
rtl/axil_pkg.sv
rtl/hdc_pkg.sv
rtl/xorshift32.sv
rtl/axil_slave_fsm.sv
rtl/hv_generator.sv
rtl/hdc_ctrl_regs.sv
rtl/hdc_top.sv
testbench/tb_hdc_top.sv

// ==== rtl/axil_pkg.sv ====
package axil_pkg;

`include "hdc_macros.svh"

    // the slave only answers okay
    typedef logic [1:0] axi_resp_t;
    localparam axi_resp_t resp_okay = 2'b00;

    typedef enum logic [2:0] {
        idle,
        aw_held,
        w_held,
        write_resp,
        read_fetch,
        read_resp
    } axil_state_t;

    // byte address bits 11:10
    typedef enum logic [1:0] {
        regs   = 2'd0,
        vector = 2'd1
    } csr_region_t;

    // word address from byte address bits 11:2
    typedef union packed {
        struct packed {
            csr_region_t region;
            logic [7:0]  index;
        } reg_view;
        struct packed {
            csr_region_t                region;
            logic [7-`HDC_WORD_IDX_W:0] spare;
            logic [`HDC_WORD_IDX_W-1:0] word;
        } vec_view;
    } csr_addr_u;

endpackage

// ==== rtl/axil_slave_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_slave_fsm
    import axil_pkg::*;
    import hdc_pkg::*;
(
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic [31:0] s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [31:0] s_axi_wdata,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    output axi_resp_t   s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    input  logic [31:0] s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    output axi_resp_t   s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    output csr_addr_u   wr_addr,
    output hv_word_t    wr_data,
    output logic        wr_en,
    output csr_addr_u   rd_addr,
    output logic        rd_en
);

    axil_state_t state;
    logic        write_go;

    // ========================================
    // channel handshakes
    // ========================================

    assign s_axi_awready = (state == idle) || (state == w_held);
    assign s_axi_wready  = (state == idle) || (state == aw_held);
    // a pending write wins over a read
    assign s_axi_arready = (state == idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == write_resp);
    assign s_axi_rvalid  = (state == read_resp);
    assign s_axi_bresp   = resp_okay;
    assign s_axi_rresp   = resp_okay;
    assign rd_en         = (state == read_fetch);

    // last missing half of a write shows up
    always_comb begin
        case (state)
            idle:    write_go = s_axi_awvalid && s_axi_wvalid;
            aw_held: write_go = s_axi_wvalid;
            w_held:  write_go = s_axi_awvalid;
            default: write_go = 1'b0;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= idle;
            wr_en <= 1'b0;
        end
        else begin
            wr_en <= write_go;
            case (state)
                idle: begin
                    if (write_go) begin
                        state <= write_resp;
                    end
                    else if (s_axi_awvalid) begin
                        state <= aw_held;
                    end
                    else if (s_axi_wvalid) begin
                        state <= w_held;
                    end
                    else if (s_axi_arvalid) begin
                        state <= read_fetch;
                    end
                end
                aw_held, w_held: begin
                    if (write_go) begin
                        state <= write_resp;
                    end
                end
                write_resp: begin
                    if (s_axi_bready) begin
                        state <= idle;
                    end
                end
                // register file needs this cycle for rdata
                read_fetch: state <= read_resp;
                read_resp: begin
                    if (s_axi_rready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ========================================
    // address and data capture
    // ========================================

    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            wr_addr <= s_axi_awaddr[11:2];
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            rd_addr <= s_axi_araddr[11:2];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hdc_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module hdc_ctrl_regs
    import axil_pkg::*;
    import hdc_pkg::*;
(
    input  logic      AXIS_ACLK,
    input  logic      S_AXI_ARESETN,
    input  csr_addr_u wr_addr,
    input  hv_word_t  wr_data,
    input  logic      wr_en,
    input  csr_addr_u rd_addr,
    input  logic      rd_en,
    input  logic      gen_done,
    input  hv_t       captured,
    output logic      gen,
    output item_idx_t item_count,
    output hv_word_t  rdata
);

    logic     reg_wr;
    hv_word_t rd_word;

    // ========================================
    // register writes
    // ========================================

    assign reg_wr = wr_en && (wr_addr.reg_view.region == regs);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            item_count <= '0;
        end
        else begin
            // completion drops the generate bit
            if (gen_done) begin
                gen <= 1'b0;
            end
            if (reg_wr) begin
                case (wr_addr.reg_view.index)
                    `HDC_OFS_CTRL:  gen <= wr_data[0];
                    `HDC_OFS_ITEMS: item_count <= wr_data[`HDC_ITEM_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // ========================================
    // read mux
    // ========================================

    always_comb begin
        rd_word = '0;
        case (rd_addr.reg_view.region)
            regs: begin
                case (rd_addr.reg_view.index)
                    `HDC_OFS_CTRL:  rd_word[0] = gen;
                    `HDC_OFS_ITEMS: rd_word[`HDC_ITEM_W-1:0] = item_count;
                    default: ;
                endcase
            end
            // window on the captured hypervector
            vector:  rd_word = captured[rd_addr.vec_view.word];
            default: ;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (rd_en) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hdc_macros.svh ====
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// hypervector geometry
`define HDC_DIM        1024
`define HDC_WORD_W     32
`define HDC_WORDS      32
`define HDC_WORD_IDX_W 5
`define HDC_ITEM_W     16

// xorshift source
`define HDC_SEED       32'h2545_f491
`define HDC_XS_A       13
`define HDC_XS_B       17
`define HDC_XS_C       5

// register word offsets in region 0
`define HDC_OFS_CTRL   8'd0
`define HDC_OFS_ITEMS  8'd1

`endif

// ==== rtl/hdc_pkg.sv ====
package hdc_pkg;

`include "hdc_macros.svh"

    // one bus word of a hypervector
    typedef logic [`HDC_WORD_W-1:0] hv_word_t;

    // full hypervector with word 0 in the low bits
    typedef hv_word_t [`HDC_WORDS-1:0] hv_t;

    // word slot inside a hypervector
    typedef logic [`HDC_WORD_IDX_W-1:0] word_idx_t;

    // item number in the item memory
    typedef logic [`HDC_ITEM_W-1:0] item_idx_t;

endpackage

// ==== rtl/hdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdc_top
    import axil_pkg::*;
    import hdc_pkg::*;
(
    input  logic        AXIS_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic [31:0] s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    output axi_resp_t   s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    input  logic [31:0] s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    output hv_word_t    s_axi_rdata,
    output axi_resp_t   s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready
);

    csr_addr_u wr_addr;
    hv_word_t  wr_data;
    logic      wr_en;
    csr_addr_u rd_addr;
    logic      rd_en;
    logic      gen;
    item_idx_t item_count;
    logic      gen_done;
    hv_t       captured;

    // ========================================
    // bus side
    // ========================================

    // byte strobes are ignored and every write sets the whole word
    axil_slave_fsm i_axil_slave_fsm (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_en         (wr_en),
        .rd_addr       (rd_addr),
        .rd_en         (rd_en)
    );

    // ========================================
    // generator and registers
    // ========================================

    hv_generator i_hv_generator (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_count    (item_count),
        .gen_done      (gen_done),
        .captured      (captured)
    );

    hdc_ctrl_regs i_hdc_ctrl_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_en         (wr_en),
        .rd_addr       (rd_addr),
        .rd_en         (rd_en),
        .gen_done      (gen_done),
        .captured      (captured),
        .gen           (gen),
        .item_count    (item_count),
        .rdata         (s_axi_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/hv_generator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module hv_generator
    import hdc_pkg::*;
(
    input  logic      AXIS_ACLK,
    input  logic      S_AXI_ARESETN,
    input  logic      gen,
    input  item_idx_t item_count,
    output logic      gen_done,
    output hv_t       captured
);

    hv_word_t  rand_word;
    word_idx_t word_cnt;
    item_idx_t item_cnt;
    logic      word_wrap;
    hv_t       work;

    xorshift32 i_xorshift (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (gen),
        .rand_word (rand_word)
    );

    // slot for the next word wraps by itself after 32 words
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_cnt <= '0;
        end
        else begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // pulse after the last word of an item
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_wrap <= 1'b0;
        end
        else begin
            word_wrap <= (word_cnt == word_idx_t'(`HDC_WORDS - 1));
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            item_cnt <= '0;
        end
        else if (word_wrap) begin
            item_cnt <= item_cnt + 1'b1;
        end
    end

    // working vector
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            work <= {`HDC_DIM{1'b0}};
        end
        else begin
            work[word_cnt] <= rand_word;
        end
    end

    assign gen_done = gen && word_wrap && (item_cnt == item_count);

    // held until the next completion
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            captured <= {`HDC_DIM{1'b0}};
        end
        else if (gen_done) begin
            captured <= work;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xorshift32.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module xorshift32
    import hdc_pkg::*;
(
    input  logic     AXIS_ACLK,
    input  logic     gen,
    output hv_word_t rand_word
);

    hv_word_t state;
    hv_word_t step_a;
    hv_word_t step_b;
    hv_word_t next_state;

    // one xorshift step in three stages
    assign step_a     = state ^ (state << `HDC_XS_A);
    assign step_b     = step_a ^ (step_a >> `HDC_XS_B);
    assign next_state = step_b ^ (step_b << `HDC_XS_C);

    // reseed while idle so every run repeats the same sequence
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            state <= `HDC_SEED;
        end
        else begin
            state <= next_state;
        end
    end

    assign rand_word = state;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_hdc_top \
    -Mdir "$build_dir" -o tb_hdc_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/tb_hdc_top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$log_file"; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0

// ==== testbench/tb_hdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module tb_hdc_top;

    localparam logic [31:0] addr_ctrl     = {22'd0, `HDC_OFS_CTRL, 2'b00};
    localparam logic [31:0] addr_items    = {22'd0, `HDC_OFS_ITEMS, 2'b00};
    localparam logic [31:0] addr_unmapped = 32'h0000_0008;
    localparam logic [31:0] addr_region2  = 32'h0000_0800;
    localparam logic [31:0] vec_base      = 32'h0000_0400;

    // generation runs with counts 0, 1, 1 and 5
    localparam int gen_cycles      = (0 + 1) * 33 + (1 + 1) * 33 + (1 + 1) * 33 + (5 + 1) * 33;
    // bus accesses besides the polling, with one last poll per run
    localparam int bus_accesses    = 25 + 4 * 3 + 2 + 5 * 32;
    localparam int watchdog_cycles = 2 * (gen_cycles + 40 * bus_accesses + 8);

    logic        AXIS_ACLK;
    logic        S_AXI_ARESETN;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    int          value_errors;
    int          protocol_errors;
    logic [31:0] rand_state;
    logic [31:0] saved [`HDC_WORDS];

    hdc_top i_dut (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    always #5 AXIS_ACLK = ~AXIS_ACLK;

    // ========================================
    // protocol properties
    // ========================================

    bvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
        $display("bvalid dropped while bready was still low");
        protocol_errors++;
    end

    rvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else begin
        $display("rvalid or rdata changed while rready was still low");
        protocol_errors++;
    end

    busy_no_ready: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (s_axi_bvalid || s_axi_rvalid) |-> !(s_axi_awready || s_axi_wready || s_axi_arready))
    else begin
        $display("a ready was high while a response was pending");
        protocol_errors++;
    end

    resp_okay: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bresp == 2'b00 && s_axi_rresp == 2'b00)
    else begin
        $display("bresp or rresp was not OKAY");
        protocol_errors++;
    end

    // ========================================
    // helpers
    // ========================================

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << `HDC_XS_A);
        s = s ^ (s >> `HDC_XS_B);
        s = s ^ (s << `HDC_XS_C);
        return s;
    endfunction

    function automatic logic [31:0] rand_next();
        rand_state = xorshift_step(rand_state);
        return rand_state;
    endfunction

    // word k of item n is step 32n+k with the seed as step 0
    function automatic logic [31:0] model_word(input int item, input int word);
        logic [31:0] s;
        s = `HDC_SEED;
        for (int i = 0; i < `HDC_WORDS * item + word; i++) begin
            s = xorshift_step(s);
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // order 0 sends both halves together while 1 and 2 send address or data first
    task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                              input int order, input int bdelay);
        logic aw_done;
        logic w_done;
        logic aw_fire;
        logic w_fire;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge AXIS_ACLK);
        s_axi_awaddr = addr;
        s_axi_wdata  = data;
        s_axi_awvalid = (order != 2);
        s_axi_wvalid  = (order != 1);
        while (!(aw_done && w_done)) begin
            #1;
            aw_fire = s_axi_awvalid && s_axi_awready;
            w_fire  = s_axi_wvalid && s_axi_wready;
            @(negedge AXIS_ACLK);
            if (aw_fire) begin
                s_axi_awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_fire) begin
                s_axi_wvalid = 1'b0;
                w_done = 1'b1;
            end
            // the missing half follows once the first one is taken
            s_axi_wvalid  = s_axi_wvalid || (aw_done && !w_done);
            s_axi_awvalid = s_axi_awvalid || (w_done && !aw_done);
        end
        #1;
        assert (s_axi_bvalid) else begin
            $display("bvalid did not rise on the edge that completed the write");
            protocol_errors++;
        end
        repeat (bdelay) @(negedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        s_axi_bready = 1'b1;
        @(negedge AXIS_ACLK);
        s_axi_bready = 1'b0;
    endtask

    task automatic send_read(input logic [31:0] addr, input int rdelay,
                             output logic [31:0] data);
        @(negedge AXIS_ACLK);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        #1;
        while (!s_axi_arready) begin
            @(negedge AXIS_ACLK);
            #1;
        end
        @(negedge AXIS_ACLK);
        s_axi_arvalid = 1'b0;
        #1;
        assert (!s_axi_rvalid) else begin
            $display("rvalid rose on the first edge after the read was accepted");
            protocol_errors++;
        end
        @(negedge AXIS_ACLK);
        #1;
        assert (s_axi_rvalid) else begin
            $display("rvalid was not high on the second edge after the read was accepted");
            protocol_errors++;
        end
        data = s_axi_rdata;
        repeat (rdelay) @(negedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        s_axi_rready = 1'b1;
        @(negedge AXIS_ACLK);
        s_axi_rready = 1'b0;
    endtask

    task automatic run_generation(input logic [31:0] count);
        logic [31:0] d;
        send_write(addr_items, count, int'(rand_next() % 32'd3), 0);
        send_write(addr_ctrl, 32'h1, 0, 0);
        d = 32'h1;
        while (d[0]) begin
            send_read(addr_ctrl, 0, d);
        end
    endtask

    task automatic check_window(input string name, input int item);
        logic [31:0] d;
        for (int k = 0; k < `HDC_WORDS; k++) begin
            send_read(vec_base + 32'(k * 4), int'(rand_next() % 32'd3), d);
            saved[k] = model_word(item, k);
            check_value($sformatf("%s word %0d", name, k), saved[k], d);
        end
    endtask

    task automatic compare_window(input string name);
        logic [31:0] d;
        for (int k = 0; k < `HDC_WORDS; k++) begin
            send_read(vec_base + 32'(k * 4), 0, d);
            check_value($sformatf("%s word %0d", name, k), saved[k], d);
        end
    endtask

    // ========================================
    // stimulus
    // ========================================

    initial begin
        logic [31:0] d;
        logic [31:0] v;
        AXIS_ACLK       = 1'b0;
        S_AXI_ARESETN   = 1'b0;
        s_axi_awaddr    = '0;
        s_axi_awvalid   = 1'b0;
        s_axi_wdata     = '0;
        s_axi_wstrb     = 4'hf;
        s_axi_wvalid    = 1'b0;
        s_axi_bready    = 1'b0;
        s_axi_araddr    = '0;
        s_axi_arvalid   = 1'b0;
        s_axi_rready    = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        rand_state      = 32'd4;

        repeat (8) @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;
        #1;
        assert (!s_axi_bvalid && !s_axi_rvalid) else begin
            $display("a valid output was high right after reset");
            protocol_errors++;
        end
        assert (s_axi_awready && s_axi_wready && s_axi_arready) else begin
            $display("a ready output was low right after reset");
            protocol_errors++;
        end
        send_read(addr_ctrl, 0, d);
        check_value("reset ctrl", 32'h0, d);
        send_read(addr_items, 0, d);
        check_value("reset items", 32'h0, d);
        send_read(vec_base, 0, d);
        check_value("reset vector word 0", 32'h0, d);

        // register readback with random orderings and delays
        for (int i = 0; i < 4; i++) begin
            v = rand_next();
            send_write(addr_items, v, i % 3, int'(rand_next() % 32'd3));
            send_read(addr_items, int'(rand_next() % 32'd3), d);
            check_value("item count readback", {16'd0, v[15:0]}, d);
        end
        send_write(addr_unmapped, rand_next(), 0, 0);
        send_read(addr_unmapped, 0, d);
        check_value("unmapped offset", 32'h0, d);
        send_write(addr_region2, 32'h1, 0, 0);
        send_read(addr_region2, 0, d);
        check_value("region 2 read", 32'h0, d);
        // item count is nonzero here, so an alias of region 0 would show
        send_read(addr_region2 + 32'h4, 0, d);
        check_value("region 2 offset 1 read", 32'h0, d);
        send_read(addr_ctrl, 0, d);
        check_value("ctrl after region 2 write", 32'h0, d);
        v = rand_next();
        send_write(addr_items | 32'h1, v, 0, 0);
        send_read(addr_items | 32'h3, 0, d);
        check_value("low address bits", {16'd0, v[15:0]}, d);

        // orderings with bready and rready held low
        send_write(addr_items, 32'h0000_1111, 1, 3);
        send_read(addr_items, 4, d);
        check_value("address first", 32'h0000_1111, d);
        send_write(addr_items, 32'h0000_2222, 2, 0);
        send_read(addr_items, 0, d);
        check_value("data first", 32'h0000_2222, d);
        send_write(addr_items, 32'h0000_3333, 0, 2);
        send_read(addr_items, 2, d);
        check_value("address and data together", 32'h0000_3333, d);

        // generation, hold and regeneration
        run_generation(32'd0);
        check_window("gen count 0", 0);
        run_generation(32'd1);
        check_window("gen count 1", 1);
        send_write(addr_items, rand_next(), 0, 0);
        send_write(addr_unmapped, rand_next(), 1, 0);
        compare_window("hold after writes");
        run_generation(32'd1);
        compare_window("regen same count");
        run_generation(32'd5);
        check_window("gen count 5", 5);

        $display("value errors: %0d  protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("test passed");
        end
        else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge AXIS_ACLK);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
